//--- logic/backup_pkg.sv
// widths, bus structs and sector limits of the backup RAM engine
// sequencer state encoding

package backup_pkg;

	// console side of the backup RAM, byte wide
	typedef logic [12:0] bram_addr_t;
	typedef logic [7:0]  bram_byte_t;

	// storage side, 16-bit words in 256-word sectors
	typedef logic [15:0] word_t;
	typedef logic [7:0]  buff_addr_t;
	typedef logic [31:0] lba_t;
	typedef logic [3:0]  sector_t;

	localparam sector_t LAST_SECTOR = 4'd15;
	// 8 KB seen as 16 sectors of 256 words
	localparam int      RAM_WORDS   = 4096;

	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_transfer,
		bk_finish
	} bk_state_t;

	// host control levels
	typedef struct packed {
		logic load;
		logic save;
		logic autosave;
		logic osd_open;
	} cfg_t;

	typedef struct packed {
		bram_addr_t addr;
		bram_byte_t wdata;
		logic       we;
	} console_bus_t;

	typedef struct packed {
		lba_t lba;
		logic rd;
		logic wr;
	} storage_req_t;

endpackage

//--- logic/backup_ram.sv
`timescale 1ns/1ps
// dual-width backup RAM
// byte port for the console, word port for the storage host

module backup_ram (
	input  logic                     clk_sys,
	input  backup_pkg::console_bus_t console,
	output backup_pkg::bram_byte_t   bram_rdata,
	input  backup_pkg::sector_t      sector,
	input  backup_pkg::buff_addr_t   sd_buff_addr,
	input  backup_pkg::word_t        sd_buff_dout,
	input  logic                     sd_buff_wr,
	input  logic                     sd_ack,
	output backup_pkg::word_t        sd_buff_din
);
	import backup_pkg::*;

	// even bytes in the low lane, odd bytes in the high lane
	bram_byte_t mem_lo [RAM_WORDS];
	bram_byte_t mem_hi [RAM_WORDS];

	logic [11:0] con_idx;
	logic [11:0] sd_idx;
	logic        sd_we;

	assign con_idx = console.addr[12:1];
	assign sd_idx  = {sector, sd_buff_addr};
	// host writes only count inside an ack window
	assign sd_we   = sd_buff_wr & sd_ack;

	always_ff @(posedge clk_sys) begin
		if (sd_we) begin
			mem_lo[sd_idx] <= sd_buff_dout[7:0];
			mem_hi[sd_idx] <= sd_buff_dout[15:8];
		end
		// console write comes last so it wins on a shared byte
		if (console.we) begin
			if (console.addr[0]) begin
				mem_hi[con_idx] <= console.wdata;
			end else begin
				mem_lo[con_idx] <= console.wdata;
			end
		end
		bram_rdata  <= console.addr[0] ? mem_hi[con_idx] : mem_lo[con_idx];
		sd_buff_din <= {mem_hi[sd_idx], mem_lo[sd_idx]};
	end

	// host must hold ack around every buffer write of a sector
	a_wr_needs_ack: assert property (@(posedge clk_sys) sd_buff_wr |-> sd_ack)
		else $error("storage write outside ack window");

endmodule

//--- logic/save_tracker.sv
`timescale 1ns/1ps
// save image enable and change-pending flags

module save_tracker (
	input  logic clk_sys,
	input  logic rst,
	input  logic console_we,
	input  logic save_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic busy,
	output logic bk_ena,
	output logic sav_pending
);

	logic old_dl;
	logic old_we;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_dl      <= 1'b0;
			old_we      <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			old_dl <= save_download;
			old_we <= console_we;

			// new download drops the old image
			if (save_download && !old_dl) begin
				bk_ena <= 1'b0;
			end
			// writable image shows up while downloading
			if (save_download && img_mounted && !img_readonly) begin
				bk_ena <= 1'b1;
			end

			// any console write marks the RAM dirty
			if (console_we && !old_we) begin
				sav_pending <= 1'b1;
			end else if (busy) begin
				sav_pending <= 1'b0;
			end
		end
	end

endmodule

//--- logic/sector_counter.sv
`timescale 1ns/1ps
// storage block address counter with last-sector flag

module sector_counter (
	input  logic             clk_sys,
	input  logic             rst,
	input  logic             clear,
	input  logic             step,
	output backup_pkg::lba_t lba,
	output logic             last
);
	import backup_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			lba <= '0;
		end else if (clear) begin
			lba <= '0;
		end else if (step) begin
			lba <= lba + lba_t'(1);
		end
	end

	assign last = (lba == lba_t'(LAST_SECTOR));

	// sequencer must stop at the last sector, never wrap past it
	a_no_step_past_last: assert property (
		@(posedge clk_sys) disable iff (rst)
		step |-> !last
	) else $error("sector step past last sector");

endmodule

//--- logic/backup_sequencer.sv
`timescale 1ns/1ps
// backup transfer FSM
// trigger detection and the storage request/ack cycle

module backup_sequencer (
	input  logic             clk_sys,
	input  logic             rst,
	input  backup_pkg::cfg_t cfg,
	input  logic             save_download,
	input  logic             bk_ena,
	input  logic             sav_pending,
	input  logic             sd_ack,
	input  logic             last,
	output logic             clear,
	output logic             step,
	output logic             rd,
	output logic             wr,
	output logic             busy,
	output logic             reload
);
	import backup_pkg::*;

	bk_state_t state;
	logic      loading;

	logic old_load;
	logic old_save;
	logic old_asave;
	logic old_dl;
	logic old_ack;

	logic asave;
	logic load_rise;
	logic save_rise;
	logic asave_rise;
	logic dl_fall;
	logic want_load;
	logic start;
	logic ack_rise;
	logic ack_fall;

	//////////////////////////////////////////////////////////////////////
	// trigger edges

	// menu closing with autosave on
	assign asave      = cfg.autosave & ~cfg.osd_open;
	assign load_rise  = cfg.load & ~old_load;
	assign save_rise  = cfg.save & ~old_save;
	assign asave_rise = asave & ~old_asave & sav_pending;
	assign dl_fall    = old_dl & ~save_download;
	assign want_load  = load_rise | dl_fall;
	assign start      = bk_ena & (load_rise | save_rise | asave_rise | dl_fall);

	assign ack_rise = sd_ack & ~old_ack;
	assign ack_fall = old_ack & ~sd_ack;

	// next sector on every falling ack but the last
	assign step  = (state == bk_transfer) & ack_fall & ~last;
	// rewind the block address once the run is over
	assign clear = (state == bk_finish);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_load  <= 1'b0;
			old_save  <= 1'b0;
			old_asave <= 1'b0;
			old_dl    <= 1'b0;
			old_ack   <= 1'b0;
		end else begin
			old_load  <= cfg.load;
			old_save  <= cfg.save;
			old_asave <= asave;
			old_dl    <= save_download;
			old_ack   <= sd_ack;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state   <= bk_idle;
			loading <= 1'b0;
			rd      <= 1'b0;
			wr      <= 1'b0;
			busy    <= 1'b0;
			reload  <= 1'b0;
		end else begin
			case (state)
				bk_idle: begin
					if (start) begin
						loading <= want_load;
						// only a manual load asks the console to reload
						reload  <= load_rise;
						rd      <= want_load;
						wr      <= ~want_load;
						busy    <= 1'b1;
						state   <= bk_request;
					end
				end
				bk_request: begin
					if (ack_rise) begin
						rd    <= 1'b0;
						wr    <= 1'b0;
						state <= bk_transfer;
					end
				end
				bk_transfer: begin
					if (ack_fall) begin
						if (last) begin
							busy    <= 1'b0;
							reload  <= 1'b0;
							loading <= 1'b0;
							state   <= bk_finish;
						end else begin
							rd    <= loading;
							wr    <= ~loading;
							state <= bk_request;
						end
					end
				end
				bk_finish: begin
					state <= bk_idle;
				end
				default: begin
					state <= bk_idle;
				end
			endcase
		end
	end

	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (rst)
		!(rd && wr)
	) else $error("rd and wr raised together");

endmodule

//--- logic/backup_top.sv
`timescale 1ns/1ps
// backup RAM save/load engine top level

module backup_top (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  backup_pkg::console_bus_t console,
	output backup_pkg::bram_byte_t   bram_rdata,
	input  backup_pkg::cfg_t         cfg,
	input  logic                     save_download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     sd_ack,
	input  backup_pkg::buff_addr_t   sd_buff_addr,
	input  backup_pkg::word_t        sd_buff_dout,
	input  logic                     sd_buff_wr,
	output backup_pkg::storage_req_t sd_req,
	output backup_pkg::word_t        sd_buff_din,
	output logic                     busy,
	output logic                     reload
);
	import backup_pkg::*;

	lba_t lba;
	logic last;
	logic clear;
	logic step;
	logic rd;
	logic wr;
	logic bk_ena;
	logic sav_pending;

	assign sd_req = '{lba: lba, rd: rd, wr: wr};

	//////////////////////////////////////////////////////////////////////
	// storage and flags

	// sector picked from the low lba bits
	backup_ram u_ram (
		.clk_sys      (clk_sys),
		.console      (console),
		.bram_rdata   (bram_rdata),
		.sector       (lba[3:0]),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din)
	);

	save_tracker u_tracker (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.console_we    (console.we),
		.save_download (save_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.busy          (busy),
		.bk_ena        (bk_ena),
		.sav_pending   (sav_pending)
	);

	//////////////////////////////////////////////////////////////////////
	// transfer control

	sector_counter u_counter (
		.clk_sys (clk_sys),
		.rst     (rst),
		.clear   (clear),
		.step    (step),
		.lba     (lba),
		.last    (last)
	);

	backup_sequencer u_seq (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.cfg           (cfg),
		.save_download (save_download),
		.bk_ena        (bk_ena),
		.sav_pending   (sav_pending),
		.sd_ack        (sd_ack),
		.last          (last),
		.clear         (clear),
		.step          (step),
		.rd            (rd),
		.wr            (wr),
		.busy          (busy),
		.reload        (reload)
	);

endmodule

//--- tests/backup_checker.sv
`timescale 1ns/1ps
// reference byte model of the backup RAM
// value comparisons, per-test result lines and closing counts

module backup_checker (
	input logic                     clk_sys,
	input backup_pkg::console_bus_t console,
	input backup_pkg::storage_req_t sd_req,
	input logic                     sd_ack,
	input logic                     sd_buff_wr,
	input backup_pkg::buff_addr_t   sd_buff_addr,
	input backup_pkg::word_t        sd_buff_dout,
	input logic                     reload,
	input logic                     bk_ena,
	input logic                     sav_pending
);
	import backup_pkg::*;

	bram_byte_t model [8192];
	string      test_name = "";
	int         test_errs = 0;
	int         total_errs = 0;
	int         tests_run = 0;
	int         tests_bad = 0;
	int         sectors_seen = 0;
	logic       exp_load = 1'b0;
	logic       exp_reload = 1'b0;

	// inputs are stable at the falling edge, the RAM takes them on the next rise
	always @(negedge clk_sys) begin
		if (sd_buff_wr && sd_ack) begin
			model[{sd_req.lba[3:0], sd_buff_addr, 1'b0}] = sd_buff_dout[7:0];
			model[{sd_req.lba[3:0], sd_buff_addr, 1'b1}] = sd_buff_dout[15:8];
		end
		// console byte lands last, same as in the RAM
		if (console.we) begin
			model[console.addr] = console.wdata;
		end
	end

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0h, actual %0h",
				test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0) begin
			tests_bad++;
		end
		$display("[%0d] %s: %s", tests_run, test_name, (test_errs == 0) ? "ok" : "FAIL");
	endtask

	task automatic print_summary();
		$display("tests run %0d, failing %0d, check errors %0d",
			tests_run, tests_bad, total_errs);
	endtask

	task automatic check_flags(input logic exp_ena, input logic exp_pend);
		check_value("bk_ena", exp_ena, bk_ena);
		check_value("sav_pending", exp_pend, sav_pending);
	endtask

	//////////////////////////////////////////////////////////////////////
	// transfer tracking

	task automatic expect_run(input logic is_load, input logic with_reload);
		exp_load     = is_load;
		exp_reload   = with_reload;
		sectors_seen = 0;
	endtask

	task automatic note_sector(input storage_req_t req);
		check_value("lba", sectors_seen, req.lba);
		check_value("rd", exp_load, req.rd);
		check_value("wr", !exp_load, req.wr);
		check_value("reload", exp_reload, reload);
		sectors_seen++;
	endtask

	task automatic close_run();
		check_value("sector count", 16, sectors_seen);
	endtask

	// word k of sector s holds bytes s*512 + 2k and s*512 + 2k + 1
	task automatic check_word(input sector_t sec, input buff_addr_t k, input word_t act);
		check_value("saved word", {model[{sec, k, 1'b1}], model[{sec, k, 1'b0}]}, act);
	endtask

	task automatic check_read(input bram_addr_t addr, input bram_byte_t act);
		check_value("console read", model[addr], act);
	endtask

endmodule

//--- tests/backup_tb.sv
`timescale 1ns/1ps
// testbench for the backup RAM engine
// clock, reset, storage host model, random stimulus and watchdog

module backup_tb;
	import backup_pkg::*;

	localparam int CLK_NS     = 100;
	localparam int RST_CYCLES = 16;
	localparam int NUM_TESTS  = 5;

	logic         clk_sys;
	logic         rst;
	console_bus_t console;
	bram_byte_t   bram_rdata;
	cfg_t         cfg;
	logic         save_download;
	logic         img_mounted;
	logic         img_readonly;
	logic         sd_ack;
	buff_addr_t   sd_buff_addr;
	word_t        sd_buff_dout;
	logic         sd_buff_wr;
	storage_req_t sd_req;
	word_t        sd_buff_din;
	logic         busy;
	logic         reload;
	logic         bk_ena;
	logic         sav_pending;
	integer       seed = 32'h0f69ead2;

	assign bk_ena      = DUT.bk_ena;
	assign sav_pending = DUT.sav_pending;

	backup_top DUT (
		.clk_sys (clk_sys), .rst (rst), .console (console), .bram_rdata (bram_rdata),
		.cfg (cfg), .save_download (save_download), .img_mounted (img_mounted),
		.img_readonly (img_readonly), .sd_ack (sd_ack), .sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout), .sd_buff_wr (sd_buff_wr), .sd_req (sd_req),
		.sd_buff_din (sd_buff_din), .busy (busy), .reload (reload)
	);

	backup_checker chk (
		.clk_sys (clk_sys), .console (console), .sd_req (sd_req), .sd_ack (sd_ack),
		.sd_buff_wr (sd_buff_wr), .sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout), .reload (reload), .bk_ena (bk_ena),
		.sav_pending (sav_pending)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// budget of 300 cycles per sector for every test, plus reset
	initial begin
		#(CLK_NS * (16 * 300 * NUM_TESTS + RST_CYCLES));
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// storage host model

	task automatic serve_sector(input logic is_load, input sector_t sec);
		int delay;
		delay = int'($unsigned($random(seed)) % 8);
		repeat (delay) @(posedge clk_sys);
		for (int i = 0; i <= 256; i++) begin
			@(posedge clk_sys);
			sd_ack       <= (i < 256);
			sd_buff_addr <= buff_addr_t'(i);
			sd_buff_wr   <= is_load && (i < 256);
			sd_buff_dout <= word_t'($random(seed));
			@(negedge clk_sys);
			// read data trails the address by one cycle
			if (!is_load && i > 0) begin
				chk.check_word(sec, buff_addr_t'(i - 1), sd_buff_din);
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk_sys);
			if (!rst && (sd_req.rd || sd_req.wr)) begin
				chk.note_sector(sd_req);
				serve_sector(sd_req.rd, sd_req.lba[3:0]);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// console and sequencing helpers

	task automatic write_random_bytes(input int count);
		repeat (count) begin
			@(posedge clk_sys);
			console.addr  <= bram_addr_t'($random(seed));
			console.wdata <= bram_byte_t'($random(seed));
			console.we    <= 1'b1;
			@(posedge clk_sys);
			console.we <= 1'b0;
		end
	endtask

	task automatic check_console_reads(input int count);
		bram_addr_t addr;
		bram_addr_t prev;
		prev = '0;
		for (int i = 0; i <= count; i++) begin
			@(posedge clk_sys);
			addr = bram_addr_t'($random(seed));
			console.addr <= addr;
			console.we   <= 1'b0;
			@(negedge clk_sys);
			if (i > 0) begin
				chk.check_read(prev, bram_rdata);
			end
			prev = addr;
		end
	endtask

	task automatic wait_transfer();
		int n;
		n = 0;
		while (!busy && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (!busy) begin
			chk.report_error("busy did not rise after the trigger");
		end else begin
			while (busy) @(negedge clk_sys);
			chk.close_run();
		end
	endtask

	task automatic expect_quiet(input int cycles);
		logic seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk_sys);
			if (busy || sd_req.rd || sd_req.wr) seen = 1'b1;
		end
		if (seen) begin
			chk.report_error("transfer started without a valid trigger");
		end
	endtask

	initial begin
		rst           = 1'b1;
		console       = '0;
		cfg           = '0;
		save_download = 1'b0;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		sd_ack        = 1'b0;
		sd_buff_addr  = '0;
		sd_buff_dout  = '0;
		sd_buff_wr    = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);

		chk.start_test("no_image");
		chk.check_flags(1'b0, 1'b0);
		chk.check_value("lba after reset", 0, sd_req.lba);
		chk.check_value("reload after reset", 0, reload);
		@(posedge clk_sys);
		cfg.load <= 1'b1;
		@(posedge clk_sys);
		cfg.load <= 1'b0;
		cfg.save <= 1'b1;
		@(posedge clk_sys);
		cfg.save <= 1'b0;
		expect_quiet(10);
		chk.finish_test();

		// writable image mounted during a download, load when it ends
		chk.start_test("download_load");
		@(posedge clk_sys);
		save_download <= 1'b1;
		img_mounted   <= 1'b1;
		repeat (4) @(posedge clk_sys);
		chk.expect_run(1'b1, 1'b0);
		save_download <= 1'b0;
		wait_transfer();
		chk.check_flags(1'b1, 1'b0);
		check_console_reads(1024);
		chk.finish_test();

		chk.start_test("manual_save");
		write_random_bytes(32);
		@(negedge clk_sys);
		chk.check_flags(1'b1, 1'b1);
		chk.expect_run(1'b0, 1'b0);
		@(posedge clk_sys);
		cfg.save <= 1'b1;
		@(posedge clk_sys);
		cfg.save <= 1'b0;
		wait_transfer();
		chk.check_flags(1'b1, 1'b0);
		chk.finish_test();

		chk.start_test("manual_load");
		chk.expect_run(1'b1, 1'b1);
		@(posedge clk_sys);
		cfg.load <= 1'b1;
		@(posedge clk_sys);
		cfg.load <= 1'b0;
		wait_transfer();
		chk.check_value("reload after busy", 0, reload);
		check_console_reads(1024);
		chk.finish_test();

		// menu close saves only with a change pending
		chk.start_test("autosave");
		@(posedge clk_sys);
		cfg.osd_open <= 1'b1;
		cfg.autosave <= 1'b1;
		write_random_bytes(4);
		chk.expect_run(1'b0, 1'b0);
		@(posedge clk_sys);
		cfg.osd_open <= 1'b0;
		wait_transfer();
		chk.check_flags(1'b1, 1'b0);
		@(posedge clk_sys);
		cfg.osd_open <= 1'b1;
		@(posedge clk_sys);
		cfg.osd_open <= 1'b0;
		expect_quiet(10);
		chk.finish_test();

		chk.print_summary();
		if (chk.total_errs == 0 && chk.tests_bad == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- project.f
logic/backup_pkg.sv
logic/backup_ram.sv
logic/save_tracker.sv
logic/sector_counter.sv
logic/backup_sequencer.sv
logic/backup_top.sv
tests/backup_checker.sv
tests/backup_tb.sv
